// File: design/modinv_pkg.sv
// Shared widths, element types and FSM encodings, imported by every design file of the matrix inverter
package modinv_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // Element and modulus width
  localparam int ELEM_W = 16;
  // Word address into the element memory
  localparam int ADDR_W = 6;
  // Matrix dimension or loop index
  localparam int DIM_W = 4;
  // Row stride, address = i * MAX_J + j
  localparam int MAX_J = 8;
  localparam int MEM_DEPTH = 1 << ADDR_W;
  // Signed Euclid coefficients, two guard bits over a residue
  localparam int COEF_W = ELEM_W + 2;

  ////////////////////
  // Types
  ////////////////////

  typedef logic [ELEM_W-1:0] elem_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DIM_W-1:0] dim_t;
  // Up to 64 counted elements, so one bit over an address
  typedef logic [ADDR_W:0] cnt_t;
  typedef logic signed [COEF_W-1:0] coef_t;

  // Sequencer walk over the matrix
  typedef enum logic [2:0] {
    IDLE,
    FETCH,
    WAIT_READ,
    INVERT,
    STORE,
    FINISH
  } seq_state_t;

  // Inverse engine
  typedef enum logic [1:0] {
    C_IDLE,
    C_STEP,
    C_DONE
  } core_state_t;

endpackage

// File: design/elem_mem_if.sv
// Request/grant bus of one master toward the element memory arbiter, one instance per master
interface elem_mem_if;
  import modinv_pkg::*;

  // Held by the master until gnt
  logic  req;
  logic  we;
  addr_t addr;
  elem_t wdata;

  // Single-cycle grant, read word follows one cycle later
  logic  gnt;
  elem_t rdata;

  // Requesting side
  modport master (
    output req,
    output we,
    output addr,
    output wdata,
    input  gnt,
    input  rdata
  );

  // Arbiter side
  modport slave (
    input  req,
    input  we,
    input  addr,
    input  wdata,
    output gnt,
    output rdata
  );

endinterface

// File: design/elem_memory.sv
// Single-port matrix element storage, driven by the arbiter with the granted master's access
module elem_memory (
  input  logic              CLK,
  input  logic              we,
  input  modinv_pkg::addr_t addr,
  input  modinv_pkg::elem_t wdata,
  output modinv_pkg::elem_t rdata
);
  import modinv_pkg::*;

  ////////////////////
  // Storage
  ////////////////////

  // One word per matrix position, row stride of MAX_J
  elem_t mem_q [MEM_DEPTH];

  // Contents undefined until the host loads them

  ////////////////////
  // Access
  ////////////////////

  // Write on the granted strobe only
  always_ff @(posedge CLK) begin
    if (we) begin
      mem_q[addr] <= wdata;
    end
  end

  // Read every cycle
  // Word for the address of cycle n appears in cycle n+1
  always_ff @(posedge CLK) begin
    rdata <= mem_q[addr];
  end

  // A write and a read of the same address in one cycle
  // returns the old word, which no master relies on

endmodule

// File: design/mem_arbiter.sv
// Fixed-priority sharing of the element memory between the host port and the sequencer
module mem_arbiter (
  input  logic              CLK,
  input  logic              RST,
  elem_mem_if.slave         host_bus,
  elem_mem_if.slave         seq_bus,
  output logic              mem_we,
  output modinv_pkg::addr_t mem_addr,
  output modinv_pkg::elem_t mem_wdata,
  input  modinv_pkg::elem_t mem_rdata
);
  import modinv_pkg::*;

  logic host_gnt;
  logic seq_gnt;
  // Owner of the access taken last cycle
  logic host_sel_q;
  logic seq_sel_q;

  ////////////////////
  // Grant logic
  ////////////////////

  // Host always first
  assign host_gnt = host_bus.req;
  // Sequencer only on a free cycle
  assign seq_gnt = seq_bus.req & ~host_bus.req;

  assign host_bus.gnt = host_gnt;
  assign seq_bus.gnt = seq_gnt;

  // Memory side follows the winner
  always_comb begin
    mem_we = 1'b0;
    mem_addr = seq_bus.addr;
    mem_wdata = seq_bus.wdata;
    if (host_gnt) begin
      mem_we = host_bus.we;
      mem_addr = host_bus.addr;
      mem_wdata = host_bus.wdata;
    end else if (seq_gnt) begin
      mem_we = seq_bus.we;
    end
  end

  ////////////////////
  // Read return
  ////////////////////

  // Remember the winner for the one-cycle read latency
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      host_sel_q <= 1'b0;
      seq_sel_q <= 1'b0;
    end else begin
      host_sel_q <= host_gnt;
      seq_sel_q <= seq_gnt;
    end
  end

  // Read word only toward last cycle's owner
  assign host_bus.rdata = host_sel_q ? mem_rdata : '0;
  assign seq_bus.rdata = seq_sel_q ? mem_rdata : '0;

endmodule

// File: design/modular_inverter_core.sv
// Extended-Euclid engine, started per element by the sequencer, one quotient step per cycle
module modular_inverter_core (
  input  logic              CLK,
  input  logic              RST,
  input  logic              start,
  input  modinv_pkg::elem_t operand,
  input  modinv_pkg::elem_t modulo,
  output logic              done,
  output logic              invertible,
  output modinv_pkg::elem_t result
);
  import modinv_pkg::*;

  core_state_t state_q;

  // Remainder pair, r0 = m and r1 = a at start
  elem_t r0_q;
  elem_t r1_q;
  // Coefficients of the operand, kept signed
  coef_t t0_q;
  coef_t t1_q;
  elem_t mod_q;
  logic  nonzero_q;

  elem_t quot;
  elem_t rem;
  coef_t t_next;
  coef_t t_norm;
  logic  load;
  logic  step;
  logic  finish;
  logic  inv_next;

  ////////////////////
  // Euclid step
  ////////////////////

  assign load = (state_q == C_IDLE) && start;
  assign step = (state_q == C_STEP) && (r1_q != '0);
  // Remainder reached zero, r0 holds the gcd
  assign finish = (state_q == C_STEP) && (r1_q == '0);

  always_comb begin
    // Divider only used while r1 is nonzero
    quot = (r1_q != '0) ? r0_q / r1_q : '0;
    rem = r0_q - quot * r1_q;
    // t0 - q * t1, true value fits COEF_W
    t_next = t0_q - $signed({{(COEF_W - ELEM_W){1'b0}}, quot}) * t1_q;
    // Bring the final coefficient into 0 .. m-1
    t_norm = t0_q[COEF_W-1] ? t0_q + $signed({{(COEF_W - ELEM_W){1'b0}}, mod_q}) : t0_q;
  end

  // gcd of 1, and zero has no inverse even for m = 1
  assign inv_next = (r0_q == elem_t'(1)) && nonzero_q;

  ////////////////////
  // Control
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q <= C_IDLE;
      invertible <= 1'b0;
    end else begin
      case (state_q)
        C_IDLE: begin
          if (start) begin
            state_q <= C_STEP;
          end
        end
        C_STEP: begin
          if (finish) begin
            invertible <= inv_next;
            state_q <= C_DONE;
          end
        end
        C_DONE: begin
          state_q <= C_IDLE;
        end
        default: begin
          state_q <= C_IDLE;
        end
      endcase
    end
  end

  // Pulse for the single C_DONE cycle
  assign done = (state_q == C_DONE);

  ////////////////////
  // Datapath
  ////////////////////

  always_ff @(posedge CLK) begin
    if (load) begin
      // Operand above m is fine, first step swaps the pair
      r0_q <= modulo;
      r1_q <= operand;
      t0_q <= '0;
      t1_q <= coef_t'(1);
      mod_q <= modulo;
      nonzero_q <= (operand != '0);
    end else if (step) begin
      r0_q <= r1_q;
      r1_q <= rem;
      t0_q <= t1_q;
      t1_q <= t_next;
    end
    // Held until the next start
    if (finish) begin
      result <= inv_next ? t_norm[ELEM_W-1:0] : '0;
    end
  end

endmodule

// File: design/tensor_inverter_sequencer.sv
// Run controller, walks the matrix row by row and replaces each element with its inverse
module tensor_inverter_sequencer (
  input  logic              CLK,
  input  logic              RST,
  input  logic              START,
  input  modinv_pkg::dim_t  size_i,
  input  modinv_pkg::dim_t  size_j,
  input  modinv_pkg::elem_t modulo,
  output logic              READY,
  output modinv_pkg::cnt_t  noninv_count,
  elem_mem_if.master        bus
);
  import modinv_pkg::*;

  seq_state_t state_q;

  // Run parameters latched on START
  dim_t  size_i_q;
  dim_t  size_j_q;
  elem_t mod_q;
  // Current element
  dim_t  i_q;
  dim_t  j_q;

  logic  last_j;
  logic  last_elem;
  logic  core_start;
  logic  core_done;
  logic  core_inv;
  elem_t core_result;

  ////////////////////
  // Walk control
  ////////////////////

  assign last_j = (j_q == size_j_q - dim_t'(1));
  assign last_elem = last_j && (i_q == size_i_q - dim_t'(1));

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q <= IDLE;
      size_i_q <= '0;
      size_j_q <= '0;
      mod_q <= '0;
      i_q <= '0;
      j_q <= '0;
      noninv_count <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          // START outside IDLE is dropped
          if (START) begin
            size_i_q <= size_i;
            size_j_q <= size_j;
            mod_q <= modulo;
            i_q <= '0;
            j_q <= '0;
            noninv_count <= '0;
            // Empty matrix, straight to READY
            state_q <= (size_i == '0 || size_j == '0) ? FINISH : FETCH;
          end
        end
        FETCH: begin
          if (bus.gnt) begin
            state_q <= WAIT_READ;
          end
        end
        // Word on bus.rdata, core started this cycle
        WAIT_READ: begin
          state_q <= INVERT;
        end
        INVERT: begin
          if (core_done) begin
            if (!core_inv) begin
              noninv_count <= noninv_count + cnt_t'(1);
            end
            state_q <= STORE;
          end
        end
        STORE: begin
          if (bus.gnt) begin
            if (last_elem) begin
              state_q <= FINISH;
            end else if (last_j) begin
              i_q <= i_q + dim_t'(1);
              j_q <= '0;
              state_q <= FETCH;
            end else begin
              j_q <= j_q + dim_t'(1);
              state_q <= FETCH;
            end
          end
        end
        FINISH: begin
          state_q <= IDLE;
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  assign READY = (state_q == FINISH);

  ////////////////////
  // Memory bus
  ////////////////////

  // Request held through FETCH and STORE until granted
  assign bus.req = (state_q == FETCH) || (state_q == STORE);
  assign bus.we = (state_q == STORE);
  assign bus.addr = addr_t'(i_q) * addr_t'(MAX_J) + addr_t'(j_q);
  // Core result is already zero for a non-invertible element
  assign bus.wdata = core_result;

  assign core_start = (state_q == WAIT_READ);

  modular_inverter_core core_i (
    .CLK        (CLK),
    .RST        (RST),
    .start      (core_start),
    .operand    (bus.rdata),
    .modulo     (mod_q),
    .done       (core_done),
    .invertible (core_inv),
    .result     (core_result)
  );

endmodule

// File: design/host_word_port.sv
// Host single-word access, one pending read or write at a time, ended by host_ack
module host_word_port (
  input  logic              CLK,
  input  logic              RST,
  input  logic              host_rd,
  input  logic              host_wr,
  input  modinv_pkg::addr_t host_addr,
  input  modinv_pkg::elem_t host_wdata,
  output logic              host_ack,
  output modinv_pkg::elem_t host_rdata,
  elem_mem_if.master        bus
);
  import modinv_pkg::*;

  // Pending request
  logic  pend_q;
  logic  we_q;
  addr_t addr_q;
  elem_t wdata_q;
  // Last read word, kept after the ack
  elem_t rdata_q;
  logic  rd_phase;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      pend_q <= 1'b0;
      we_q <= 1'b0;
      host_ack <= 1'b0;
    end else begin
      // Ack one cycle after the grant, read word valid then too
      host_ack <= bus.gnt;
      if (bus.gnt) begin
        pend_q <= 1'b0;
      end else if (!pend_q && (host_rd || host_wr)) begin
        pend_q <= 1'b1;
        // Write wins if both strobes arrive together
        we_q <= host_wr;
      end
    end
  end

  // Payload only, no reset
  always_ff @(posedge CLK) begin
    if (!pend_q && (host_rd || host_wr)) begin
      addr_q <= host_addr;
      wdata_q <= host_wdata;
    end
    if (rd_phase) begin
      rdata_q <= bus.rdata;
    end
  end

  assign rd_phase = host_ack && !we_q;
  // Word from the memory in the ack cycle, held copy afterwards
  assign host_rdata = rd_phase ? bus.rdata : rdata_q;

  assign bus.req = pend_q;
  assign bus.we = we_q;
  assign bus.addr = addr_q;
  assign bus.wdata = wdata_q;

endmodule

// File: design/modinv_matrix_top.sv
// Top level of the matrix modular inverter, host word port and run control on plain ports
module modinv_matrix_top (
  input  logic              CLK,
  input  logic              RST,
  // Host word access
  input  logic              host_rd,
  input  logic              host_wr,
  input  modinv_pkg::addr_t host_addr,
  input  modinv_pkg::elem_t host_wdata,
  output logic              host_ack,
  output modinv_pkg::elem_t host_rdata,
  // Run control
  input  logic              START,
  input  modinv_pkg::dim_t  size_i,
  input  modinv_pkg::dim_t  size_j,
  input  modinv_pkg::elem_t modulo,
  output logic              READY,
  output modinv_pkg::cnt_t  noninv_count
);
  import modinv_pkg::*;

  ////////////////////
  // Buses
  ////////////////////

  // One bus per master
  elem_mem_if host_bus ();
  elem_mem_if seq_bus ();

  // Arbiter to memory
  logic  mem_we;
  addr_t mem_addr;
  elem_t mem_wdata;
  elem_t mem_rdata;

  ////////////////////
  // Instances
  ////////////////////

  host_word_port host_word_port_i (
    .CLK        (CLK),
    .RST        (RST),
    .host_rd    (host_rd),
    .host_wr    (host_wr),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .host_ack   (host_ack),
    .host_rdata (host_rdata),
    .bus        (host_bus.master)
  );

  tensor_inverter_sequencer tensor_inverter_sequencer_i (
    .CLK          (CLK),
    .RST          (RST),
    .START        (START),
    .size_i       (size_i),
    .size_j       (size_j),
    .modulo       (modulo),
    .READY        (READY),
    .noninv_count (noninv_count),
    .bus          (seq_bus.master)
  );

  // Host ahead of the sequencer
  mem_arbiter mem_arbiter_i (
    .CLK       (CLK),
    .RST       (RST),
    .host_bus  (host_bus.slave),
    .seq_bus   (seq_bus.slave),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata)
  );

  elem_memory elem_memory_i (
    .CLK   (CLK),
    .we    (mem_we),
    .addr  (mem_addr),
    .wdata (mem_wdata),
    .rdata (mem_rdata)
  );

endmodule

// File: verification/modinv_matrix_assertions.sv
// Concurrent checks on grants, run completion and engine handshake, bound into arbiter and sequencer
module modinv_matrix_assertions (
  input logic CLK,
  input logic RST,
  input logic host_gnt,
  input logic seq_gnt,
  input logic host_req,
  input logic ready,
  input logic core_start,
  input logic core_done
);
  timeunit 1ns;
  timeprecision 100ps;

  // Failed assertions, read by the testbench at the end of the run
  int   fail_count = 0;
  // Engine started and not yet done
  logic armed_q;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      armed_q <= 1'b0;
    end else if (core_start) begin
      armed_q <= 1'b1;
    end else if (core_done) begin
      armed_q <= 1'b0;
    end
  end

  ////////////////////
  // Arbiter
  ////////////////////

  grants_exclusive: assert property (@(posedge CLK) disable iff (RST)
    !(host_gnt && seq_gnt))
    else begin
      $error("Host and sequencer granted in the same cycle");
      fail_count++;
    end

  // Host priority
  seq_yields_to_host: assert property (@(posedge CLK) disable iff (RST)
    seq_gnt |-> !host_req)
    else begin
      $error("Sequencer granted while the host requests");
      fail_count++;
    end

  ////////////////////
  // Sequencer and core
  ////////////////////

  ready_single_pulse: assert property (@(posedge CLK) disable iff (RST)
    ready |=> !ready)
    else begin
      $error("READY held longer than one cycle");
      fail_count++;
    end

  done_after_start: assert property (@(posedge CLK) disable iff (RST)
    core_done |-> armed_q)
    else begin
      $error("Core done without a start since the previous done");
      fail_count++;
    end

endmodule

// Grant checks only, run signals tied off
bind mem_arbiter modinv_matrix_assertions arbiter_checks_i (
  .CLK        (CLK),
  .RST        (RST),
  .host_gnt   (host_gnt),
  .seq_gnt    (seq_gnt),
  .host_req   (host_bus.req),
  .ready      (1'b0),
  .core_start (1'b0),
  .core_done  (1'b0)
);

// Run and engine checks only, grants tied off
bind tensor_inverter_sequencer modinv_matrix_assertions sequencer_checks_i (
  .CLK        (CLK),
  .RST        (RST),
  .host_gnt   (1'b0),
  .seq_gnt    (1'b0),
  .host_req   (1'b0),
  .ready      (READY),
  .core_start (core_start),
  .core_done  (core_done)
);

// File: verification/modinv_matrix_tb.sv
// Directed testbench for the matrix modular inverter, host loads and reads words around each run
module modinv_matrix_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import modinv_pkg::*;

  localparam int NUM_TESTS = 5;
  // 64 elements, 40 cycles each, per test, plus margin
  localparam int TIMEOUT_CYCLES = MEM_DEPTH * 40 * NUM_TESTS + 2000;

  logic  CLK;
  logic  RST;
  logic  host_rd;
  logic  host_wr;
  addr_t host_addr;
  elem_t host_wdata;
  logic  host_ack;
  elem_t host_rdata;
  logic  START;
  dim_t  size_i;
  dim_t  size_j;
  elem_t modulo;
  logic  READY;
  cnt_t  noninv_count;

  // Expected memory image
  elem_t exp_mem [MEM_DEPTH];
  int    seed;
  int    cycle_count;
  int    ready_count;

  modinv_matrix_top modinv_matrix_top_i (
    .CLK          (CLK),
    .RST          (RST),
    .host_rd      (host_rd),
    .host_wr      (host_wr),
    .host_addr    (host_addr),
    .host_wdata   (host_wdata),
    .host_ack     (host_ack),
    .host_rdata   (host_rdata),
    .START        (START),
    .size_i       (size_i),
    .size_j       (size_j),
    .modulo       (modulo),
    .READY        (READY),
    .noninv_count (noninv_count)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  // READY seen at the edge that ends its cycle
  always @(posedge CLK) begin
    cycle_count++;
    if (READY) begin
      ready_count++;
    end
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the DUT stopped responding", cycle_count);
      $display("Test FAILED");
      $fatal(1, "Run aborted on timeout");
    end
  end

  ////////////////////
  // Helpers
  ////////////////////

  // Brute-force search, 0 when no inverse exists
  function automatic elem_t ref_inverse(elem_t a, elem_t m);
    longint x;
    for (x = 1; x < longint'(m); x++) begin
      if ((x * longint'(a)) % longint'(m) == 1) begin
        return elem_t'(x);
      end
    end
    return '0;
  endfunction

  task automatic check_value(string what, int addr, int got, int exp);
    assert (got == exp) else begin
      $display("[ERROR] %0t: %s at %0d is 0x%0h, expected 0x%0h", $time, what, addr, got, exp);
      $display("Test FAILED");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  // Called and returning on a falling edge
  task automatic host_write(addr_t a, elem_t d);
    host_wr = 1'b1;
    host_addr = a;
    host_wdata = d;
    @(negedge CLK);
    host_wr = 1'b0;
    while (!host_ack) @(negedge CLK);
    exp_mem[a] = d;
  endtask

  task automatic host_read(addr_t a, output elem_t d);
    host_rd = 1'b1;
    host_addr = a;
    @(negedge CLK);
    host_rd = 1'b0;
    while (!host_ack) @(negedge CLK);
    d = host_rdata;
  endtask

  task automatic check_all(string what);
    elem_t d;
    for (int a = 0; a < MEM_DEPTH; a++) begin
      host_read(addr_t'(a), d);
      check_value(what, a, int'(d), int'(exp_mem[a]));
    end
  endtask

  task automatic pulse_start(dim_t si, dim_t sj, elem_t m);
    START = 1'b1;
    size_i = si;
    size_j = sj;
    modulo = m;
    @(negedge CLK);
    START = 1'b0;
  endtask

  task automatic run_matrix(dim_t si, dim_t sj, elem_t m);
    int target;
    target = ready_count + 1;
    pulse_start(si, sj, m);
    while (ready_count < target) @(negedge CLK);
  endtask

  // Updates the image in place, returns the zero count
  task automatic apply_model(int si, int sj, elem_t m, output int noninv);
    int a;
    noninv = 0;
    for (int i = 0; i < si; i++) begin
      for (int j = 0; j < sj; j++) begin
        a = i * MAX_J + j;
        exp_mem[a] = ref_inverse(exp_mem[a], m);
        if (exp_mem[a] == '0) begin
          noninv++;
        end
      end
    end
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic readback_all_words();
    for (int a = 0; a < MEM_DEPTH; a++) begin
      host_write(addr_t'(a), elem_t'($random(seed)));
    end
    check_all("read-back");
  endtask

  task automatic prime_full_run();
    int noninv;
    elem_t v;
    for (int a = 0; a < MEM_DEPTH; a++) begin
      // Every seventh word zero
      v = (a % 7 == 0) ? elem_t'(0) : elem_t'($unsigned($random(seed)) % 251);
      host_write(addr_t'(a), v);
    end
    apply_model(8, 8, elem_t'(251), noninv);
    run_matrix(4'd8, 4'd8, elem_t'(251));
    check_value("noninv_count", 0, int'(noninv_count), noninv);
    check_all("prime 8x8 result");
  endtask

  task automatic composite_partial_run();
    int noninv;
    for (int i = 0; i < 3; i++) begin
      for (int j = 0; j < 5; j++) begin
        host_write(addr_t'(i * MAX_J + j), elem_t'($unsigned($random(seed)) % 100));
      end
    end
    apply_model(3, 5, elem_t'(100), noninv);
    run_matrix(4'd3, 4'd5, elem_t'(100));
    check_value("noninv_count", 0, int'(noninv_count), noninv);
    // Outside the 3x5 region the image is unchanged
    check_all("composite 3x5 result");
  endtask

  task automatic contention_run();
    int noninv;
    int target;
    elem_t d;
    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < 4; j++) begin
        host_write(addr_t'(i * MAX_J + j), elem_t'($unsigned($random(seed)) % 251));
      end
    end
    apply_model(4, 4, elem_t'(251), noninv);
    target = ready_count + 1;
    pulse_start(4'd4, 4'd4, elem_t'(251));
    // Corner word, never touched by a 4x4 run
    while (ready_count < target) begin
      host_read(addr_t'(63), d);
      check_value("read during run", 63, int'(d), int'(exp_mem[63]));
    end
    check_value("noninv_count", 0, int'(noninv_count), noninv);
    check_all("4x4 result under contention");
  endtask

  task automatic edge_size_runs();
    int target;
    run_matrix(4'd0, 4'd3, elem_t'(251));
    check_value("noninv_count", 0, int'(noninv_count), 0);
    check_all("empty run");
    host_write(addr_t'(0), elem_t'(1));
    target = ready_count + 1;
    pulse_start(4'd1, 4'd1, elem_t'(2));
    // Sent while busy, both dropped
    pulse_start(4'd8, 4'd8, elem_t'(251));
    pulse_start(4'd8, 4'd8, elem_t'(251));
    while (ready_count < target) @(negedge CLK);
    repeat (30) @(negedge CLK);
    check_value("READY count", 0, ready_count, target);
    exp_mem[0] = ref_inverse(elem_t'(1), elem_t'(2));
    check_value("noninv_count", 0, int'(noninv_count), 0);
    check_all("1x1 modulo 2 result");
  endtask

  ////////////////////
  // Sequence
  ////////////////////

  initial begin
    seed = 22;
    cycle_count = 0;
    ready_count = 0;
    RST = 1'b1;
    host_rd = 1'b0;
    host_wr = 1'b0;
    host_addr = '0;
    host_wdata = '0;
    START = 1'b0;
    size_i = '0;
    size_j = '0;
    modulo = '0;
    repeat (2) @(negedge CLK);
    RST = 1'b0;
    @(negedge CLK);
    readback_all_words();
    prime_full_run();
    composite_partial_run();
    contention_run();
    edge_size_runs();
    if (modinv_matrix_top_i.mem_arbiter_i.arbiter_checks_i.fail_count +
        modinv_matrix_top_i.tensor_inverter_sequencer_i.sequencer_checks_i.fail_count != 0) begin
      $display("Concurrent assertions failed during the run");
      $display("Test FAILED");
      $fatal(1, "Run ended with assertion failures");
    end else begin
      $display("Test OK");
      $finish;
    end
  end

endmodule

// File: modinv_matrix.f
design/modinv_pkg.sv
design/elem_mem_if.sv
design/elem_memory.sv
design/mem_arbiter.sv
design/modular_inverter_core.sv
design/tensor_inverter_sequencer.sv
design/host_word_port.sv
design/modinv_matrix_top.sv
verification/modinv_matrix_assertions.sv
verification/modinv_matrix_tb.sv
